// File: src/addIdxPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the ADD IX/IY,pp slice
// every RTL module takes what it needs by a wildcard import
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package addIdxPkg;

    localparam int dataWidth = 8;
    localparam int wordWidth = 16;
    localparam int numPairs  = 6;

    // index prefixes
    localparam logic [dataWidth-1:0] prefixIx = 8'hDD;
    localparam logic [dataWidth-1:0] prefixIy = 8'hFD;

    // positions inside F
    localparam int flagC = 0;
    localparam int flagN = 1;
    localparam int flagH = 4;

    typedef enum logic [2:0] {
        bcPair = 3'd0,
        dePair = 3'd1,
        hlPair = 3'd2,
        spPair = 3'd3,
        ixPair = 3'd4,
        iyPair = 3'd5
    } regPair;

    typedef enum logic [1:0] {
        idleStep   = 2'd0,
        lowStep    = 2'd1,
        highStep   = 2'd2,
        reportStep = 2'd3
    } stepState;

    typedef struct packed {
        logic [dataWidth-1:0] prefix;
        logic [dataWidth-1:0] opcode;
    } instrWord;

    typedef struct packed {
        regPair               target;
        logic [wordWidth-1:0] value;
    } regLoad;

    typedef struct packed {
        logic   legal;
        regPair srcPair;
        logic   isY;
        logic   selHigh;
        logic   wrIdxLow;
        logic   wrIdxHigh;
        logic   wrFlagC;
        logic   wrFlagN;
        logic   wrFlagH;
        logic   useSavedCarry;
    } ctrlWord;

    typedef struct packed {
        logic                 supported;
        regPair               dest;
        logic [wordWidth-1:0] value;
        logic [dataWidth-1:0] fAfter;
        logic [dataWidth-1:0] fBefore;
    } addResult;

endpackage

// File: src/byteAlu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit adder with half carry out of bit 3 and carry out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module byteAlu import addIdxPkg::*; (
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] sum,
    output logic                 halfCarry,
    output logic                 carryOut
);

    logic [4:0] lowNibble;
    logic [4:0] highNibble;

    // split at bit 4 so the nibble carry is visible
    assign lowNibble  = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'b0, carryIn};
    assign highNibble = {1'b0, opA[7:4]} + {1'b0, opB[7:4]} + {4'b0, lowNibble[4]};

    assign sum = {highNibble[3:0], lowNibble[3:0]};

    // on the high byte this is the bit 11 carry of the word
    assign halfCarry = lowNibble[4];
    assign carryOut  = highNibble[4];

endmodule

// File: src/opDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decodes DD/FD 00pp1001 and the current step into strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opDecoder import addIdxPkg::*; (
    input  instrWord instr,
    input  stepState step,
    output ctrlWord  ctrl
);

    logic       isIxPrefix;
    logic       isIyPrefix;
    logic       opMatch;
    logic       legal;
    logic [1:0] pp;

    logic lowEnable;
    logic highEnable;
    logic lowWrite;
    logic highWrite;

    regPair idxPair;
    regPair srcPair;

    // prefix match
    assign isIxPrefix = (instr.prefix == prefixIx);
    assign isIyPrefix = (instr.prefix == prefixIy);

    // 00pp1001
    assign opMatch = (instr.opcode[7:6] == 2'b00) && (instr.opcode[3:0] == 4'b1001);

    assign legal = (isIxPrefix | isIyPrefix) & opMatch;
    assign pp    = instr.opcode[5:4];

    assign idxPair = isIyPrefix ? iyPair : ixPair;

    // pp = 10 names the index register itself, not HL
    always_comb begin
        case (pp)
            2'b00:   srcPair = bcPair;
            2'b01:   srcPair = dePair;
            2'b10:   srcPair = idxPair;
            default: srcPair = spPair;
        endcase
    end

    assign lowEnable  = (step == lowStep);
    assign highEnable = (step == highStep);

    // an unsupported pair walks through the steps without writing
    assign lowWrite  = lowEnable & legal;
    assign highWrite = highEnable & legal;

    assign ctrl.legal   = legal;
    assign ctrl.srcPair = srcPair;
    assign ctrl.isY     = isIyPrefix;

    // low step: low bytes, carry in forced to 0
    assign ctrl.wrIdxLow = lowWrite;

    // high step: high bytes with the saved carry, flags land here
    assign ctrl.selHigh       = highEnable;
    assign ctrl.useSavedCarry = highEnable;
    assign ctrl.wrIdxHigh     = highWrite;
    assign ctrl.wrFlagC       = highWrite;
    assign ctrl.wrFlagN       = highWrite;
    assign ctrl.wrFlagH       = highWrite;

endmodule

// File: src/stepSequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// step counter FSM with instruction and result handshakes
// holds the instruction and the low-byte carry between steps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module stepSequencer import addIdxPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     instrValid,
    output logic     instrReady,
    input  instrWord instr,
    output instrWord curInstr,
    input  logic     legal,
    input  logic     useCarry,
    input  logic     carryOut,
    output stepState step,
    output logic     savedCarry,
    output logic     resValid,
    input  logic     resReady
);

    stepState stepQ;
    stepState stepD;
    instrWord instrQ;
    logic     carryQ;
    logic     accept;

    assign instrReady = (stepQ == idleStep);
    assign resValid   = (stepQ == reportStep);
    assign accept     = instrValid & instrReady;

    always_comb begin
        stepD = stepQ;
        case (stepQ)
            idleStep:   if (accept) stepD = lowStep;
            lowStep:    stepD = legal ? highStep : reportStep;
            highStep:   stepD = reportStep;
            reportStep: if (resReady) stepD = idleStep;
            default:    stepD = idleStep;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stepQ <= idleStep;
        end else begin
            stepQ <= stepD;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instrQ <= instr;
        end
        if (stepQ == lowStep) begin
            carryQ <= carryOut;
        end
    end

    assign step       = stepQ;
    assign curInstr   = instrQ;
    assign savedCarry = carryQ & useCarry;

    // a result waiting on the consumer must not vanish
    holdResult: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid);

endmodule

// File: src/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register pairs and F, byte operand selects, result record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module regFile import addIdxPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 loadValid,
    input  regLoad               load,
    input  ctrlWord              ctrl,
    input  logic [dataWidth-1:0] sum,
    input  logic                 halfCarry,
    input  logic                 carryOut,
    output logic [dataWidth-1:0] opA,
    output logic [dataWidth-1:0] opB,
    output addResult             res
);

    logic [wordWidth-1:0] pairQ [numPairs];
    logic [dataWidth-1:0] fQ;
    logic [dataWidth-1:0] fPrevQ;

    regPair               idxSel;
    logic [wordWidth-1:0] idxWord;
    logic [wordWidth-1:0] srcWord;

    assign idxSel  = ctrl.isY ? iyPair : ixPair;
    assign idxWord = pairQ[idxSel];
    assign srcWord = pairQ[ctrl.srcPair];

    // index register on A, source pair on B
    assign opA = ctrl.selHigh ? idxWord[15:8] : idxWord[7:0];
    assign opB = ctrl.selHigh ? srcWord[15:8] : srcWord[7:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numPairs; i++) begin
                pairQ[i] <= '0;
            end
            fQ <= '0;
        end else begin
            if (ctrl.wrIdxLow) begin
                pairQ[idxSel][7:0] <= sum;
            end
            if (ctrl.wrIdxHigh) begin
                pairQ[idxSel][15:8] <= sum;
            end
            // S, Z and P/V are left alone
            if (ctrl.wrFlagC) begin
                fQ[flagC] <= carryOut;
            end
            if (ctrl.wrFlagN) begin
                fQ[flagN] <= 1'b0;
            end
            if (ctrl.wrFlagH) begin
                fQ[flagH] <= halfCarry;
            end
            if (loadValid) begin
                pairQ[load.target] <= load.value;
            end
        end
    end

    // snapshot of F taken while the low byte is written
    always_ff @(posedge clk) begin
        if (ctrl.wrIdxLow) begin
            fPrevQ <= fQ;
        end
    end

    assign res.supported = ctrl.legal;
    assign res.dest      = idxSel;
    assign res.value     = idxWord;
    assign res.fAfter    = fQ;
    assign res.fBefore   = ctrl.legal ? fPrevQ : fQ;

    // both halves of one add go to the same index register
    sameIndex: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.wrIdxLow |=> ctrl.wrIdxHigh && ctrl.isY == $past(ctrl.isY));

    // preloads only arrive while the sequencer is idle
    loadWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        loadValid |-> !(ctrl.selHigh || ctrl.wrIdxLow || ctrl.wrIdxHigh));

endmodule

// File: src/addIdxTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADD IX/IY,pp execution slice, one instruction in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module addIdxTop import addIdxPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     instrValid,
    output logic     instrReady,
    input  instrWord instr,
    input  logic     loadValid,
    input  regLoad   load,
    output logic     resValid,
    input  logic     resReady,
    output addResult res
);

    stepState             step;
    instrWord             curInstr;
    ctrlWord              ctrl;
    logic                 savedCarry;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] sum;
    logic                 halfCarry;
    logic                 carryOut;

    stepSequencer seq (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instr(instr),
        .curInstr(curInstr),
        .legal(ctrl.legal),
        .useCarry(ctrl.useSavedCarry),
        .carryOut(carryOut),
        .step(step),
        .savedCarry(savedCarry),
        .resValid(resValid),
        .resReady(resReady)
    );

    opDecoder dec (
        .instr(curInstr),
        .step(step),
        .ctrl(ctrl)
    );

    regFile regs (
        .clk(clk),
        .rstN(rstN),
        .loadValid(loadValid),
        .load(load),
        .ctrl(ctrl),
        .sum(sum),
        .halfCarry(halfCarry),
        .carryOut(carryOut),
        .opA(opA),
        .opB(opB),
        .res(res)
    );

    byteAlu alu (
        .opA(opA),
        .opB(opB),
        .carryIn(savedCarry),
        .sum(sum),
        .halfCarry(halfCarry),
        .carryOut(carryOut)
    );

endmodule

// File: bench/addIdxTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the ADD IX/IY,pp slice that checks every result
// against a reference model of the pairs and F
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module addIdxTb import addIdxPkg::*; ();

    localparam int halfPeriod     = 20;
    localparam int driveDelay     = 5;
    localparam int resetCycles    = 8;
    localparam int randomCount    = 12;
    localparam int stallCount     = 8;
    // reset add, index self adds with read-backs, edge carries, illegal pairs
    localparam int fixedCount     = 15;
    localparam int cyclesPerInstr = 40;
    localparam int maxCycles      = resetCycles
                                  + cyclesPerInstr * (randomCount + stallCount + fixedCount);

    logic     clk;
    logic     rstN;
    logic     instrValid;
    logic     instrReady;
    instrWord instr;
    logic     loadValid;
    regLoad   load;
    logic     resValid;
    logic     resReady;
    addResult res;

    logic [numPairs-1:0][wordWidth-1:0] model;
    logic [dataWidth-1:0]               fModel;
    addResult                           expQ [$];
    string                              nameQ [$];

    integer   seed;
    int       errors;
    int       checks;
    int       cycles;
    int       acceptCycle;
    logic     awaitFirst;
    logic     holding;
    addResult heldRes;
    logic     stallOn;

    addIdxTop uut (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instr(instr),
        .loadValid(loadValid),
        .load(load),
        .resValid(resValid),
        .resReady(resReady),
        .res(res)
    );

    // expected record from the Z80 rule for ADD IX/IY,pp
    function automatic addResult expectedResult(
        input logic [dataWidth-1:0]               prefix,
        input logic [dataWidth-1:0]               opcode,
        input logic [numPairs-1:0][wordWidth-1:0] pairs,
        input logic [dataWidth-1:0]               fOld
    );
        addResult    r;
        logic        legalOp;
        regPair      idx;
        regPair      src;
        logic [16:0] full;
        logic [12:0] low12;

        legalOp = (prefix == prefixIx || prefix == prefixIy)
                && opcode[7:6] == 2'b00 && opcode[3:0] == 4'b1001;
        idx = (prefix == prefixIy) ? iyPair : ixPair;
        case (opcode[5:4])
            2'b00:   src = bcPair;
            2'b01:   src = dePair;
            2'b10:   src = idx;
            default: src = spPair;
        endcase
        full  = {1'b0, pairs[idx]} + {1'b0, pairs[src]};
        low12 = {1'b0, pairs[idx][11:0]} + {1'b0, pairs[src][11:0]};
        r.supported = legalOp;
        r.dest      = idx;
        r.fBefore   = fOld;
        r.fAfter    = fOld;
        r.value     = pairs[idx];
        if (legalOp) begin
            r.value         = full[15:0];
            r.fAfter[flagC] = full[16];
            r.fAfter[flagN] = 1'b0;
            r.fAfter[flagH] = low12[12];
        end
        return r;
    endfunction

    task automatic loadPair(input regPair pair, input logic [wordWidth-1:0] value);
        loadValid   = 1'b1;
        load.target = pair;
        load.value  = value;
        @(posedge clk);
        #driveDelay;
        loadValid   = 1'b0;
        model[pair] = value;
    endtask

    // issues one instruction and returns once its result has been taken
    task automatic runInstr(input string name, input logic [dataWidth-1:0] prefix,
                            input logic [dataWidth-1:0] opcode);
        addResult e;

        e = expectedResult(prefix, opcode, model, fModel);
        expQ.push_back(e);
        nameQ.push_back(name);
        if (e.supported) begin
            model[e.dest] = e.value;
            fModel        = e.fAfter;
        end
        instr.prefix = prefix;
        instr.opcode = opcode;
        instrValid   = 1'b1;
        while (!instrReady) begin
            @(posedge clk);
            #driveDelay;
        end
        @(posedge clk);
        #driveDelay;
        instrValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
            #driveDelay;
        end
    endtask

    // adding a zero BC shows both index registers as they stand
    task automatic readBackIndex(input string name);
        loadPair(bcPair, 16'h0000);
        runInstr({name, " ix"}, prefixIx, 8'h09);
        runInstr({name, " iy"}, prefixIy, 8'h09);
    endtask

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("checked %0d results, %0d errors", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #driveDelay;
        if (stallOn) begin
            resReady = (($random(seed) & 3) == 0);
        end else begin
            resReady = 1'b1;
        end
    end

    // sampled at the falling edge where inputs and outputs have settled
    always @(negedge clk) begin : resultCheck
        addResult e;
        string    n;
        int       want;

        if (rstN) begin
            // ready stays low from acceptance until the result is taken
            if ((awaitFirst || resValid) && instrReady) begin
                $display("the instruction input is ready while an instruction is in flight");
                errors++;
            end
            if (instrValid && instrReady) begin
                acceptCycle = cycles;
                awaitFirst  = 1'b1;
            end
            if (resValid && awaitFirst) begin
                awaitFirst = 1'b0;
                if (expQ.size() != 0) begin
                    want = expQ[0].supported ? 3 : 2;
                    if (cycles - acceptCycle != want) begin
                        $display("[FAIL] %s latency: expected %0d, actual %0d",
                                 nameQ[0], want, cycles - acceptCycle);
                        errors++;
                    end
                end
            end
            if (holding && !resValid) begin
                $display("a result was dropped while the consumer was not ready");
                errors++;
            end
            if (holding && resValid && res !== heldRes) begin
                $display("[FAIL] %s held: expected %h, actual %h", nameQ[0], heldRes, res);
                errors++;
            end
            holding = resValid && !resReady;
            heldRes = res;
            if (resValid && resReady) begin
                if (expQ.size() == 0) begin
                    $display("a result came out with no instruction outstanding");
                    errors++;
                end else begin
                    e = expQ.pop_front();
                    n = nameQ.pop_front();
                    checks++;
                    if (e.supported && res !== e) begin
                        $display("[FAIL] %s: expected %h, actual %h", n, e, res);
                        errors++;
                    end
                    if (!e.supported && res.supported !== 1'b0) begin
                        $display("[FAIL] %s supported: expected 0, actual %b", n, res.supported);
                        errors++;
                    end
                    if (!e.supported && res.fAfter !== e.fAfter) begin
                        $display("[FAIL] %s F: expected %h, actual %h", n, e.fAfter, res.fAfter);
                        errors++;
                    end
                    if (!e.supported && res.fBefore !== e.fBefore) begin
                        $display("[FAIL] %s F before: expected %h, actual %h",
                                 n, e.fBefore, res.fBefore);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [1:0]           pp;
        logic [dataWidth-1:0] pfx;
        regPair               idx;
        regPair               src;

        seed        = 96;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        acceptCycle = 0;
        awaitFirst  = 1'b0;
        holding     = 1'b0;
        heldRes     = '0;
        stallOn     = 1'b0;
        model       = '0;
        fModel      = '0;
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        loadValid   = 1'b0;
        load        = '0;
        resReady    = 1'b1;

        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        if (resValid !== 1'b0 || instrReady !== 1'b1) begin
            $display("after reset a result is valid or the instruction input is not ready");
            errors++;
        end
        runInstr("reset add ix,bc", prefixIx, 8'h09);

        for (int i = 0; i < randomCount; i++) begin
            pfx = (i % 2 == 1) ? prefixIy : prefixIx;
            idx = (pfx == prefixIy) ? iyPair : ixPair;
            case (i % 3)
                0:       src = bcPair;
                1:       src = dePair;
                default: src = spPair;
            endcase
            pp = (src == bcPair) ? 2'b00 : (src == dePair) ? 2'b01 : 2'b11;
            loadPair(idx, 16'($random(seed)));
            loadPair(src, 16'($random(seed)));
            runInstr($sformatf("random add %0d", i), pfx, {2'b00, pp, 4'b1001});
        end

        // pp = 10 names the prefix-selected index register
        loadPair(ixPair, 16'($random(seed)));
        loadPair(iyPair, 16'($random(seed)));
        runInstr("add iy,iy", prefixIy, 8'h29);
        readBackIndex("after add iy,iy");
        runInstr("add ix,ix", prefixIx, 8'h29);
        readBackIndex("after add ix,ix");

        loadPair(ixPair, 16'hFFFF);
        loadPair(bcPair, 16'h0001);
        runInstr("edge ffff+0001", prefixIx, 8'h09);
        loadPair(ixPair, 16'h0FFF);
        loadPair(dePair, 16'h0001);
        runInstr("edge 0fff+0001", prefixIx, 8'h19);
        loadPair(iyPair, 16'h8000);
        loadPair(spPair, 16'h8000);
        runInstr("edge 8000+8000", prefixIy, 8'h39);

        loadPair(ixPair, 16'($random(seed)));
        loadPair(iyPair, 16'($random(seed)));
        runInstr("illegal ed 09", 8'hED, 8'h09);
        runInstr("illegal dd 0a", prefixIx, 8'h0A);
        runInstr("illegal fd 49", prefixIy, 8'h49);
        readBackIndex("after illegal");

        stallOn = 1'b1;
        for (int i = 0; i < stallCount; i++) begin
            pfx = (($random(seed) & 1) != 0) ? prefixIy : prefixIx;
            pp  = 2'($random(seed));
            loadPair(ixPair, 16'($random(seed)));
            loadPair(iyPair, 16'($random(seed)));
            runInstr($sformatf("stalled add %0d", i), pfx, {2'b00, pp, 4'b1001});
        end
        stallOn = 1'b0;

        $display("checked %0d results, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: all.f
src/addIdxPkg.sv
src/byteAlu.sv
src/opDecoder.sv
src/stepSequencer.sv
src/regFile.sv
src/addIdxTop.sv
bench/addIdxTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = addIdxTb
RTL_TOP   = addIdxTop
FILELIST  = all.f
OBJDIR    = obj_dir
PASSMSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
